// File: design/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

    localparam int XLEN       = 64;
    localparam int INST_W     = 32;
    localparam int OPC_W      = 7;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;
    localparam int FUNC_W     = 2;

    // Major opcodes in inst[6:0]
    localparam logic [OPC_W-1:0] OPC_LUI       = 7'b0110111;
    localparam logic [OPC_W-1:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [OPC_W-1:0] OPC_JAL       = 7'b1101111;
    localparam logic [OPC_W-1:0] OPC_JALR      = 7'b1100111;
    localparam logic [OPC_W-1:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [OPC_W-1:0] OPC_LOAD      = 7'b0000011;
    localparam logic [OPC_W-1:0] OPC_STORE     = 7'b0100011;
    localparam logic [OPC_W-1:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [OPC_W-1:0] OPC_OP        = 7'b0110011;
    localparam logic [OPC_W-1:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [OPC_W-1:0] OPC_OP_32     = 7'b0111011;
    localparam logic [OPC_W-1:0] OPC_SYSTEM    = 7'b1110011;

    // funct3 values the decoder tests directly
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_PRIV = 3'b000; // ecall, ebreak, mret

    // funct7 values for OP and OP-32
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // SUB, SRA
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // Execute unit select
    localparam logic [FUNC_W-1:0] FUNC_ALU = 2'd0;
    localparam logic [FUNC_W-1:0] FUNC_MUL = 2'd1;
    localparam logic [FUNC_W-1:0] FUNC_DIV = 2'd2;
    localparam logic [FUNC_W-1:0] FUNC_CSR = 2'd3;

endpackage

`default_nettype wire

// File: design/riscv_pipe_pkg.sv
`default_nettype none

package riscv_pipe_pkg;

    import riscv_isa_pkg::*;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [INST_W-1:0] inst;
    } fd_payload_t;

    typedef struct packed {
        logic [3:0]            b_condition; // [3] branch, [2:0] funct3
        logic                  oprnd1sel;   // 1 selects pc
        logic                  oprnd2sel;   // 1 selects imm
        logic [1:0]            storesrc;    // Store size
        logic [5:0]            alucontrol;  // [4] word, [3] alt, [2:0] funct3
        logic [3:0]            mulctrl;
        logic [3:0]            divctrl;
        logic [FUNC_W-1:0]     funcsel;
        logic                  memwrite;
        logic                  memread;
        logic [2:0]            memext;
        logic [1:0]            resultsrc;   // ALU, mem, pc+4, CSR
        logic                  regwrite;
        logic                  jump;
        logic [OPC_W-1:0]      opcode;
        logic                  ecall;
        logic                  illegal;
        logic                  iscsr;
        logic [2:0]            csrop;
        logic                  immreg;
        logic [CSR_ADDR_W-1:0] csraddress;
    } de_ctrl_t;

    typedef struct packed {
        logic                  instret;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pcplus4;
        logic [XLEN-1:0]       rs1data;
        logic [XLEN-1:0]       rs2data;
        logic [XLEN-1:0]       extendedimm;
        logic [XLEN-1:0]       immzeroextend;
        logic [REG_ADDR_W-1:0] rs1addr;
        logic [REG_ADDR_W-1:0] rs2addr;
        logic [REG_ADDR_W-1:0] rdaddr;
        de_ctrl_t              ctrl;
    } de_payload_t;

endpackage

`default_nettype wire

// File: design/riscv_pipe_reg.sv
`timescale 1ns/100ps
`default_nettype none

module riscv_pipe_reg #(
    parameter type T_PAYLOAD = logic
) (
    input  logic     i_riscv_de_clk,
    input  logic     i_riscv_de_rst,
    input  logic     i_riscv_de_flush,
    input  logic     i_riscv_de_stall,
    input  T_PAYLOAD i_riscv_de_d,
    output T_PAYLOAD o_riscv_de_q
);

    always_ff @(posedge i_riscv_de_clk or posedge i_riscv_de_rst)
    begin
        if (i_riscv_de_rst)
        begin
            o_riscv_de_q <= '0;
        end
        else if (i_riscv_de_flush)
        begin
            o_riscv_de_q <= '0; // Flush wins over stall
        end
        else if (!i_riscv_de_stall)
        begin
            o_riscv_de_q <= i_riscv_de_d;
        end
    end

endmodule

`default_nettype wire

// File: design/riscv_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module riscv_decoder
    import riscv_isa_pkg::*;
    import riscv_pipe_pkg::*;
(
    input  logic [INST_W-1:0]     i_riscv_de_inst,
    input  logic                  i_riscv_de_valid,
    output de_ctrl_t              o_riscv_de_ctrl,
    output logic [XLEN-1:0]       o_riscv_de_extendedimm,
    output logic [XLEN-1:0]       o_riscv_de_immzeroextend,
    output logic [REG_ADDR_W-1:0] o_riscv_de_rs1addr,
    output logic [REG_ADDR_W-1:0] o_riscv_de_rs2addr,
    output logic [REG_ADDR_W-1:0] o_riscv_de_rdaddr
);

    logic [INST_W-1:0] inst;
    logic [OPC_W-1:0]  opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [6:0]        shift_hi;
    logic              word_op;
    logic              illegal;

    assign inst     = i_riscv_de_inst;
    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign word_op  = (opcode == OPC_OP_IMM_32) || (opcode == OPC_OP_32);
    assign shift_hi = word_op ? funct7 : {inst[31:26], 1'b0}; // RV64 shamt is 6 bits

    assign o_riscv_de_rdaddr        = inst[11:7];
    assign o_riscv_de_rs1addr       = (opcode == OPC_LUI) ? '0 : inst[19:15]; // LUI adds to x0
    assign o_riscv_de_rs2addr       = inst[24:20];
    assign o_riscv_de_immzeroextend = {{(XLEN-REG_ADDR_W){1'b0}}, inst[19:15]};

    always_comb
    begin
        case (opcode)
            OPC_LUI, OPC_AUIPC:
                o_riscv_de_extendedimm = {{(XLEN-31){inst[31]}}, inst[30:12], 12'b0};
            OPC_JAL:
                o_riscv_de_extendedimm = {{(XLEN-20){inst[31]}}, inst[19:12], inst[20],
                                          inst[30:21], 1'b0};
            OPC_BRANCH:
                o_riscv_de_extendedimm = {{(XLEN-12){inst[31]}}, inst[7], inst[30:25],
                                          inst[11:8], 1'b0};
            OPC_STORE:
                o_riscv_de_extendedimm = {{(XLEN-11){inst[31]}}, inst[30:25], inst[11:7]};
            default:
                o_riscv_de_extendedimm = {{(XLEN-11){inst[31]}}, inst[30:20]};
        endcase
    end

    always_comb
    begin
        o_riscv_de_ctrl            = '0;
        o_riscv_de_ctrl.funcsel    = FUNC_ALU;
        o_riscv_de_ctrl.opcode     = opcode;
        o_riscv_de_ctrl.memext     = funct3;
        o_riscv_de_ctrl.csraddress = inst[31:20];
        illegal                    = 1'b0;
        case (opcode)
            OPC_LUI, OPC_AUIPC:
            begin
                o_riscv_de_ctrl.oprnd1sel = (opcode == OPC_AUIPC);
                o_riscv_de_ctrl.oprnd2sel = 1'b1;
                o_riscv_de_ctrl.regwrite  = 1'b1;
            end
            OPC_JAL, OPC_JALR:
            begin
                o_riscv_de_ctrl.oprnd1sel = (opcode == OPC_JAL);
                o_riscv_de_ctrl.oprnd2sel = 1'b1;
                o_riscv_de_ctrl.resultsrc = 2'd2; // Link is pc + 4
                o_riscv_de_ctrl.regwrite  = 1'b1;
                o_riscv_de_ctrl.jump      = 1'b1;
                illegal                   = (opcode == OPC_JALR) && (funct3 != F3_ADD);
            end
            OPC_BRANCH:
            begin
                o_riscv_de_ctrl.b_condition = {1'b1, funct3};
                o_riscv_de_ctrl.oprnd1sel   = 1'b1; // Target is pc + imm
                o_riscv_de_ctrl.oprnd2sel   = 1'b1;
                illegal                     = (funct3[2:1] == 2'b01);
            end
            OPC_LOAD:
            begin
                o_riscv_de_ctrl.memread   = 1'b1;
                o_riscv_de_ctrl.regwrite  = 1'b1;
                o_riscv_de_ctrl.resultsrc = 2'd1;
                o_riscv_de_ctrl.oprnd2sel = 1'b1;
                illegal                   = (funct3 == 3'b111);
            end
            OPC_STORE:
            begin
                o_riscv_de_ctrl.memwrite  = 1'b1;
                o_riscv_de_ctrl.oprnd2sel = 1'b1;
                o_riscv_de_ctrl.storesrc  = funct3[1:0];
                illegal                   = funct3[2];
            end
            OPC_OP_IMM, OPC_OP_IMM_32:
            begin
                o_riscv_de_ctrl.oprnd2sel  = 1'b1;
                o_riscv_de_ctrl.regwrite   = 1'b1;
                o_riscv_de_ctrl.alucontrol = {1'b0, word_op, 1'b0, funct3};
                case (funct3)
                    F3_SLL:
                        illegal = (shift_hi != F7_BASE);
                    F3_SR:
                    begin
                        o_riscv_de_ctrl.alucontrol[3] = inst[30];
                        illegal = (shift_hi != F7_BASE) && (shift_hi != F7_ALT);
                    end
                    default:
                        illegal = word_op && (funct3 != F3_ADD); // Only ADDIW
                endcase
            end
            OPC_OP, OPC_OP_32:
            begin
                o_riscv_de_ctrl.regwrite = 1'b1;
                if (funct7 == F7_MULDIV)
                begin
                    if (!funct3[2])
                    begin
                        o_riscv_de_ctrl.funcsel = FUNC_MUL;
                        o_riscv_de_ctrl.mulctrl = {word_op, funct3};
                        illegal                 = word_op && (funct3 != F3_ADD); // MULW only
                    end
                    else
                    begin
                        o_riscv_de_ctrl.funcsel = FUNC_DIV;
                        o_riscv_de_ctrl.divctrl = {word_op, funct3};
                    end
                end
                else if ((funct7 == F7_BASE) || (funct7 == F7_ALT))
                begin
                    o_riscv_de_ctrl.alucontrol = {1'b0, word_op, funct7[5], funct3};
                    illegal = ((funct7 == F7_ALT) && (funct3 != F3_ADD) && (funct3 != F3_SR))
                           || (word_op && (funct3 != F3_ADD) && (funct3 != F3_SLL)
                                       && (funct3 != F3_SR));
                end
                else
                begin
                    illegal = 1'b1;
                end
            end
            OPC_SYSTEM:
            begin
                if (funct3 == F3_PRIV)
                begin
                    illegal               = (inst[31:7] != '0); // ebreak, mret, wfi
                    o_riscv_de_ctrl.ecall = !illegal;
                end
                else
                begin
                    o_riscv_de_ctrl.iscsr     = 1'b1;
                    o_riscv_de_ctrl.csrop     = funct3;
                    o_riscv_de_ctrl.immreg    = funct3[2];
                    o_riscv_de_ctrl.funcsel   = FUNC_CSR;
                    o_riscv_de_ctrl.resultsrc = 2'd3;
                    o_riscv_de_ctrl.regwrite  = 1'b1;
                    illegal                   = (funct3 == 3'b100);
                end
            end
            default:
                illegal = 1'b1;
        endcase

        o_riscv_de_ctrl.illegal = illegal && i_riscv_de_valid; // Bubbles are not illegal
        if (illegal || !i_riscv_de_valid)
        begin
            o_riscv_de_ctrl.regwrite = 1'b0;
            o_riscv_de_ctrl.memwrite = 1'b0;
            o_riscv_de_ctrl.memread  = 1'b0;
            o_riscv_de_ctrl.jump     = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/riscv_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module riscv_regfile
    import riscv_isa_pkg::*;
(
    input  logic                  i_riscv_de_clk,
    input  logic                  i_riscv_de_rst,
    input  logic                  i_riscv_de_wb_regwrite,
    input  logic [REG_ADDR_W-1:0] i_riscv_de_wb_rdaddr,
    input  logic [XLEN-1:0]       i_riscv_de_wb_data,
    input  logic [REG_ADDR_W-1:0] i_riscv_de_rs1addr,
    input  logic [REG_ADDR_W-1:0] i_riscv_de_rs2addr,
    output logic [XLEN-1:0]       o_riscv_de_rs1data,
    output logic [XLEN-1:0]       o_riscv_de_rs2data
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic            wr_en;

    assign wr_en = i_riscv_de_wb_regwrite && (i_riscv_de_wb_rdaddr != '0);

    // Write data bypasses the array on a same-cycle hit
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        else if (wr_en && (i_riscv_de_wb_rdaddr == addr))
            return i_riscv_de_wb_data;
        else
            return regs[addr];
    endfunction

    always_comb
    begin
        o_riscv_de_rs1data = read_port(i_riscv_de_rs1addr);
        o_riscv_de_rs2data = read_port(i_riscv_de_rs2addr);
    end

    always_ff @(posedge i_riscv_de_clk or posedge i_riscv_de_rst)
    begin
        if (i_riscv_de_rst)
        begin
            for (int i = 0; i < 2**REG_ADDR_W; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
        begin
            regs[i_riscv_de_wb_rdaddr] <= i_riscv_de_wb_data;
        end
    end

endmodule

`default_nettype wire

// File: design/riscv_de_stage.sv
`timescale 1ns/100ps
`default_nettype none

module riscv_de_stage
    import riscv_isa_pkg::*;
    import riscv_pipe_pkg::*;
(
    input  logic                  i_riscv_de_clk,
    input  logic                  i_riscv_de_rst,
    input  logic [INST_W-1:0]     i_riscv_de_inst,
    input  logic [XLEN-1:0]       i_riscv_de_pc,
    input  logic                  i_riscv_de_valid,
    input  logic                  i_riscv_de_stall,
    input  logic                  i_riscv_de_fd_flush,
    input  logic                  i_riscv_de_de_flush,
    input  logic                  i_riscv_de_wb_regwrite,
    input  logic [REG_ADDR_W-1:0] i_riscv_de_wb_rdaddr,
    input  logic [XLEN-1:0]       i_riscv_de_wb_data,
    output de_payload_t           o_riscv_de_payload
);

    fd_payload_t           fd_d;
    fd_payload_t           fd_q;
    de_payload_t           de_d;
    de_ctrl_t              ctrl;
    logic [XLEN-1:0]       extendedimm;
    logic [XLEN-1:0]       immzeroextend;
    logic [XLEN-1:0]       rs1data;
    logic [XLEN-1:0]       rs2data;
    logic [REG_ADDR_W-1:0] rs1addr;
    logic [REG_ADDR_W-1:0] rs2addr;
    logic [REG_ADDR_W-1:0] rdaddr;

    assign fd_d = '{valid: i_riscv_de_valid, pc: i_riscv_de_pc, inst: i_riscv_de_inst};

    riscv_pipe_reg #(
        .T_PAYLOAD (fd_payload_t)
    ) u_fd_reg (
        .i_riscv_de_clk   (i_riscv_de_clk),
        .i_riscv_de_rst   (i_riscv_de_rst),
        .i_riscv_de_flush (i_riscv_de_fd_flush),
        .i_riscv_de_stall (i_riscv_de_stall),
        .i_riscv_de_d     (fd_d),
        .o_riscv_de_q     (fd_q)
    );

    riscv_decoder u_decoder (
        .i_riscv_de_inst          (fd_q.inst),
        .i_riscv_de_valid         (fd_q.valid),
        .o_riscv_de_ctrl          (ctrl),
        .o_riscv_de_extendedimm   (extendedimm),
        .o_riscv_de_immzeroextend (immzeroextend),
        .o_riscv_de_rs1addr       (rs1addr),
        .o_riscv_de_rs2addr       (rs2addr),
        .o_riscv_de_rdaddr        (rdaddr)
    );

    riscv_regfile u_regfile (
        .i_riscv_de_clk         (i_riscv_de_clk),
        .i_riscv_de_rst         (i_riscv_de_rst),
        .i_riscv_de_wb_regwrite (i_riscv_de_wb_regwrite),
        .i_riscv_de_wb_rdaddr   (i_riscv_de_wb_rdaddr),
        .i_riscv_de_wb_data     (i_riscv_de_wb_data),
        .i_riscv_de_rs1addr     (rs1addr),
        .i_riscv_de_rs2addr     (rs2addr),
        .o_riscv_de_rs1data     (rs1data),
        .o_riscv_de_rs2data     (rs2data)
    );

    assign de_d = '{
        instret:       fd_q.valid && !ctrl.illegal, // Retires only if it decoded
        pc:            fd_q.pc,
        pcplus4:       fd_q.pc + XLEN'(4),
        rs1data:       rs1data,
        rs2data:       rs2data,
        extendedimm:   extendedimm,
        immzeroextend: immzeroextend,
        rs1addr:       rs1addr,
        rs2addr:       rs2addr,
        rdaddr:        rdaddr,
        ctrl:          ctrl
    };

    riscv_pipe_reg #(
        .T_PAYLOAD (de_payload_t)
    ) u_de_reg (
        .i_riscv_de_clk   (i_riscv_de_clk),
        .i_riscv_de_rst   (i_riscv_de_rst),
        .i_riscv_de_flush (i_riscv_de_de_flush),
        .i_riscv_de_stall (i_riscv_de_stall),
        .i_riscv_de_d     (de_d),
        .o_riscv_de_q     (o_riscv_de_payload)
    );

endmodule

`default_nettype wire

// File: dv/riscv_de_stage_assert.sv
`timescale 1ns/100ps
`default_nettype none

module riscv_de_stage_assert
    import riscv_pipe_pkg::*;
(
    input logic        i_riscv_de_clk,
    input logic        i_riscv_de_rst,
    input logic        i_riscv_de_de_flush,
    input de_payload_t o_riscv_de_payload
);

    // A flushed slot never retires
    assert property (@(posedge i_riscv_de_clk) disable iff (i_riscv_de_rst)
        i_riscv_de_de_flush |=> !o_riscv_de_payload.instret)
        else $error("instret set after de flush");

    assert property (@(posedge i_riscv_de_clk) disable iff (i_riscv_de_rst)
        o_riscv_de_payload.ctrl.regwrite |-> o_riscv_de_payload.instret)
        else $error("regwrite without instret");

    assert property (@(posedge i_riscv_de_clk) disable iff (i_riscv_de_rst)
        o_riscv_de_payload.ctrl.illegal |-> !o_riscv_de_payload.ctrl.memwrite)
        else $error("memwrite on illegal instruction");

endmodule

bind riscv_de_stage riscv_de_stage_assert u_assert (.*);

`default_nettype wire

// File: dv/riscv_de_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module riscv_de_stage_tb
    import riscv_isa_pkg::*;
    import riscv_pipe_pkg::*;
;

    localparam int    PERIOD   = 100;
    localparam int    NROWS    = 16;
    localparam int    NEXTRA   = 6;  // Regfile writes and reads after the table
    localparam time   WATCHDOG = (NROWS + NEXTRA) * 4 * PERIOD + 4 * PERIOD;

    typedef struct packed {
        logic [INST_W-1:0] inst;
        logic [XLEN-1:0]   pc;
        logic              valid;
        logic [1:0]        stall;        // Cycles of stall while in decode
        logic              fd_flush;
        logic              de_flush;
        logic              exp_instret;
        logic [FUNC_W-1:0] exp_funcsel;
        logic [5:0]        exp_alu;
        logic              exp_regwrite;
        logic [XLEN-1:0]   exp_imm;
        logic [4:0]        exp_rd;
        logic              exp_illegal;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic [INST_W-1:0]     inst;
    logic [XLEN-1:0]       pc;
    logic                  valid;
    logic                  stall;
    logic                  fd_flush;
    logic                  de_flush;
    logic                  wb_regwrite;
    logic [REG_ADDR_W-1:0] wb_rdaddr;
    logic [XLEN-1:0]       wb_data;
    de_payload_t           payload;
    row_t                  rows [NROWS];
    int                    errors;
    logic [XLEN-1:0]       rdata;

    riscv_de_stage i_dut (
        .i_riscv_de_clk         (clk),
        .i_riscv_de_rst         (rst),
        .i_riscv_de_inst        (inst),
        .i_riscv_de_pc          (pc),
        .i_riscv_de_valid       (valid),
        .i_riscv_de_stall       (stall),
        .i_riscv_de_fd_flush    (fd_flush),
        .i_riscv_de_de_flush    (de_flush),
        .i_riscv_de_wb_regwrite (wb_regwrite),
        .i_riscv_de_wb_rdaddr   (wb_rdaddr),
        .i_riscv_de_wb_data     (wb_data),
        .o_riscv_de_payload     (payload)
    );

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG);
        $display("Watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    // ADD rd, rs1, x0
    function automatic row_t add_row(input logic [4:0] rd, input logic [4:0] rs1);
        return '{{7'd0, 5'd0, rs1, 3'd0, rd, OPC_OP}, 64'h3000, 1'b1, 2'd0, 1'b0, 1'b0,
                 1'b1, FUNC_ALU, 6'd0, 1'b1, 64'd0, rd, 1'b0};
    endfunction

    task automatic write_reg(input logic [4:0] addr, input logic [XLEN-1:0] data);
        wb_regwrite = 1'b1;
        wb_rdaddr   = addr;
        wb_data     = data;
        @(negedge clk);
        wb_regwrite = 1'b0;
    endtask

    // Runs from one falling edge to the falling edge after the result lands
    task automatic run_row(input int idx, input row_t r, input logic late_wb);
        de_payload_t held;
        int          errs_before;
        errs_before = errors;
        inst        = r.inst;
        pc          = r.pc;
        valid       = r.valid;
        fd_flush    = r.fd_flush;
        @(negedge clk);
        inst        = '0;
        pc          = '0;
        valid       = 1'b0;
        fd_flush    = 1'b0;
        wb_regwrite = late_wb; // Write lands while the row is decoded
        held        = payload;
        stall       = (r.stall != 2'd0);
        for (int k = 0; k < int'(r.stall); k++)
        begin
            @(negedge clk);
            check_value("payload_held", 64'(payload == held), 64'd1);
        end
        stall    = 1'b0;
        de_flush = r.de_flush;
        @(negedge clk);
        de_flush    = 1'b0;
        wb_regwrite = 1'b0;
        check_value("instret", 64'(payload.instret), 64'(r.exp_instret));
        check_value("funcsel", 64'(payload.ctrl.funcsel), 64'(r.exp_funcsel));
        check_value("alucontrol", 64'(payload.ctrl.alucontrol), 64'(r.exp_alu));
        check_value("regwrite", 64'(payload.ctrl.regwrite), 64'(r.exp_regwrite));
        check_value("extendedimm", payload.extendedimm, r.exp_imm);
        check_value("rdaddr", 64'(payload.rdaddr), 64'(r.exp_rd));
        check_value("illegal", 64'(payload.ctrl.illegal), 64'(r.exp_illegal));
        if (r.exp_illegal)
            check_value("memwrite", 64'(payload.ctrl.memwrite), 64'd0);
        if (!r.fd_flush && !r.de_flush)
            check_value("pcplus4", payload.pcplus4, r.pc + 64'd4);
        if (errors != errs_before)
            $display("Row %0d failed, pc=%h rdaddr=%0d", idx, r.pc, r.exp_rd);
    endtask

    initial
    begin
        // inst, pc, valid, stall, fd_flush, de_flush,
        // instret, funcsel, alu, regwrite, imm, rd, illegal
        rows[0]  = '{32'hFFB10093, 64'h1000, 1'b1, 2'd0, 1'b0, 1'b0, 1'b1, FUNC_ALU, 6'd0,
                     1'b1, 64'hFFFF_FFFF_FFFF_FFFB, 5'd1, 1'b0};  // addi x1,x2,-5
        rows[1]  = '{32'h123451B7, 64'h1004, 1'b1, 2'd0, 1'b0, 1'b0, 1'b1, FUNC_ALU, 6'd0,
                     1'b1, 64'h1234_5000, 5'd3, 1'b0};            // lui x3
        rows[2]  = '{32'h010000EF, 64'h1008, 1'b1, 2'd0, 1'b0, 1'b0, 1'b1, FUNC_ALU, 6'd0,
                     1'b1, 64'd16, 5'd1, 1'b0};                   // jal x1,+16
        rows[3]  = '{32'hFE208CE3, 64'h100C, 1'b1, 2'd0, 1'b0, 1'b0, 1'b1, FUNC_ALU, 6'd0,
                     1'b0, 64'hFFFF_FFFF_FFFF_FFF8, 5'd25, 1'b0}; // beq x1,x2,-8
        rows[4]  = '{32'h00813203, 64'h1010, 1'b1, 2'd0, 1'b0, 1'b0, 1'b1, FUNC_ALU, 6'd0,
                     1'b1, 64'd8, 5'd4, 1'b0};                    // ld x4,8(x2)
        rows[5]  = '{32'h00513623, 64'h1014, 1'b1, 2'd0, 1'b0, 1'b0, 1'b1, FUNC_ALU, 6'd0,
                     1'b0, 64'd12, 5'd12, 1'b0};                  // sd x5,12(x2)
        rows[6]  = '{32'h02208333, 64'h1018, 1'b1, 2'd0, 1'b0, 1'b0, 1'b1, FUNC_MUL, 6'd0,
                     1'b1, 64'h22, 5'd6, 1'b0};                   // mul x6,x1,x2
        rows[7]  = '{32'h0220C3BB, 64'h101C, 1'b1, 2'd0, 1'b0, 1'b0, 1'b1, FUNC_DIV, 6'd0,
                     1'b1, 64'h22, 5'd7, 1'b0};                   // divw x7,x1,x2
        rows[8]  = '{32'h3002D473, 64'h1020, 1'b1, 2'd0, 1'b0, 1'b0, 1'b1, FUNC_CSR, 6'd0,
                     1'b1, 64'h300, 5'd8, 1'b0};                  // csrrwi x8,0x300,5
        rows[9]  = '{32'h0000007F, 64'h1024, 1'b1, 2'd0, 1'b0, 1'b0, 1'b0, FUNC_ALU, 6'd0,
                     1'b0, 64'd0, 5'd0, 1'b1};                    // Undefined opcode
        rows[10] = '{32'h002084B3, 64'h1028, 1'b1, 2'd0, 1'b1, 1'b0, 1'b0, FUNC_ALU, 6'd0,
                     1'b0, 64'd0, 5'd0, 1'b0};                    // add with fd flush
        rows[11] = '{32'hFFB10093, 64'h102C, 1'b1, 2'd0, 1'b0, 1'b1, 1'b0, FUNC_ALU, 6'd0,
                     1'b0, 64'd0, 5'd0, 1'b0};                    // addi with de flush
        rows[12] = '{32'hFFB10093, 64'h1030, 1'b1, 2'd2, 1'b0, 1'b0, 1'b1, FUNC_ALU, 6'd0,
                     1'b1, 64'hFFFF_FFFF_FFFF_FFFB, 5'd1, 1'b0};  // Stalled 2 cycles
        rows[13] = '{32'hFFB10093, 64'h1034, 1'b0, 2'd0, 1'b0, 1'b0, 1'b0, FUNC_ALU, 6'd0,
                     1'b0, 64'hFFFF_FFFF_FFFF_FFFB, 5'd1, 1'b0};  // Bubble
        rows[14] = '{32'h4020853B, 64'h1038, 1'b1, 2'd0, 1'b0, 1'b0, 1'b1, FUNC_ALU, 6'h18,
                     1'b1, 64'h402, 5'd10, 1'b0};                 // subw x10,x1,x2
        rows[15] = '{32'h00517623, 64'h103C, 1'b1, 2'd0, 1'b0, 1'b0, 1'b0, FUNC_ALU, 6'd0,
                     1'b0, 64'd12, 5'd12, 1'b1};                  // Store with funct3 111
    end

    initial
    begin
        errors      = 0;
        rst         = 1'b1;
        inst        = '0;
        pc          = '0;
        valid       = 1'b0;
        stall       = 1'b0;
        fd_flush    = 1'b0;
        de_flush    = 1'b0;
        wb_regwrite = 1'b0;
        wb_rdaddr   = '0;
        wb_data     = '0;
        void'($urandom(59391));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("reset_payload", 64'(payload == '0), 64'd1);

        for (int i = 0; i < NROWS; i++)
            run_row(i, rows[i], 1'b0);

        rdata = {$urandom, $urandom};
        write_reg(5'd5, rdata);
        run_row(NROWS, add_row(5'd7, 5'd5), 1'b0);
        check_value("rs1data_x5", payload.rs1data, rdata);

        write_reg(5'd0, {$urandom, $urandom});
        run_row(NROWS + 1, add_row(5'd9, 5'd0), 1'b0);
        check_value("rs1data_x0", payload.rs1data, 64'd0);

        rdata     = {$urandom, $urandom};
        wb_rdaddr = 5'd6;
        wb_data   = rdata;
        run_row(NROWS + 2, add_row(5'd8, 5'd6), 1'b1);
        check_value("rs1data_bypass", payload.rs1data, rdata);

        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
design/riscv_isa_pkg.sv
design/riscv_pipe_pkg.sv
design/riscv_pipe_reg.sv
design/riscv_decoder.sv
design/riscv_regfile.sv
design/riscv_de_stage.sv
dv/riscv_de_stage_assert.sv
dv/riscv_de_stage_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module riscv_de_stage_tb -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^=== PASS ===$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
